// ==== src/gem_pkg.sv ====
`default_nettype none

// --------------------------------------------------------------------------
// Shared types and constants for the GEM trigger link front end
// --------------------------------------------------------------------------

package gem_pkg;

    // Cluster field widths
    typedef logic [10:0] strip_addr_t;                   // Strip address within the chamber
    typedef logic [2:0]  cluster_size_t;                 // Number of strips in the cluster

    // One packed cluster, address in the low bits and size on top
    typedef logic [$bits(cluster_size_t)+$bits(strip_addr_t)-1:0] gem_cluster_t;

    localparam int clusters_per_frame = 4;               // Clusters carried by one link frame

    // One trigger frame from the link, cluster0 in the lowest bits
    typedef logic [clusters_per_frame*$bits(gem_cluster_t)-1:0] gem_frame_t;

    // Top two address bits set means the cluster slot is empty
    localparam logic [1:0] invalid_addr_prefix = 2'b11;

    // Raw hits capture sequence
    typedef enum logic [1:0] {
        capture_idle    = 2'd0,                          // Armed, waiting for first valid cluster
        capture_writing = 2'd1,                          // Recording frames into the lanes
        capture_readout = 2'd2                           // Record frozen, held for readout
    } capture_state_t;

endpackage

`default_nettype wire

// ==== src/gem_cluster_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

// --------------------------------------------------------------------------
// Frame decoder: splits a link frame into four clusters, one cycle latency
// --------------------------------------------------------------------------

module gem_cluster_decode (
    input  wire logic                clock,
    input  wire logic                reset,
    input  wire gem_pkg::gem_frame_t frame,              // One frame per clock from the link
    output gem_pkg::gem_cluster_t    cluster0,           // Lowest 14 bits of the frame
    output gem_pkg::gem_cluster_t    cluster1,
    output gem_pkg::gem_cluster_t    cluster2,
    output gem_pkg::gem_cluster_t    cluster3,           // Highest 14 bits of the frame
    output logic [3:0]               vpf,                // Valid pattern flag per cluster
    output logic                     nonzero             // Any bit of the frame set
);

    localparam int cluster_width = $bits(gem_pkg::gem_cluster_t);
    localparam int addr_width    = $bits(gem_pkg::strip_addr_t);

    gem_pkg::gem_cluster_t slice      [gem_pkg::clusters_per_frame]; // Raw frame slices
    gem_pkg::strip_addr_t  slice_addr [gem_pkg::clusters_per_frame]; // Address field per slice
    logic [gem_pkg::clusters_per_frame-1:0] slice_valid;             // Prefix check per slice

    // Slice the frame and check each address prefix
    for (genvar i = 0; i < gem_pkg::clusters_per_frame; i++) begin : g_slice
        assign slice[i]       = frame[i*cluster_width +: cluster_width];
        assign slice_addr[i]  = slice[i][addr_width-1:0];
        assign slice_valid[i] = slice_addr[i][addr_width-1 -: 2] != gem_pkg::invalid_addr_prefix;
    end

    // --------------------------------------------------------------------------
    // Output register stage
    // --------------------------------------------------------------------------

    always_ff @(posedge clock) begin
        if (reset) begin
            cluster0 <= '0;
            cluster1 <= '0;
            cluster2 <= '0;
            cluster3 <= '0;
            vpf      <= '0;                              // No valid clusters until first frame
            nonzero  <= 1'b0;
        end else begin
            cluster0 <= slice[0];
            cluster1 <= slice[1];
            cluster2 <= slice[2];
            cluster3 <= slice[3];
            vpf      <= slice_valid;
            nonzero  <= |frame;                          // OR of all 56 bits
        end
    end

endmodule

`default_nettype wire

// ==== src/gem_capture_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

// --------------------------------------------------------------------------
// Raw hits capture control: arm, trigger, write sweep, hold for readout
// --------------------------------------------------------------------------

module gem_capture_ctrl #(
    parameter int capture_depth_log2 = 10                // Capture depth is 2**capture_depth_log2
) (
    input  wire logic                          clock,
    input  wire logic                          reset,
    input  wire logic                          resync,       // Returns to idle like reset
    input  wire logic                          rearm,        // Releases the held record
    input  wire logic [3:0]                    vpf,          // Decoded valid flags
    output logic                               wr_en,        // Lane write strobe
    output logic [capture_depth_log2-1:0]      wr_addr,      // Lane write address
    output logic                               capture_full  // Record complete and held
);

    localparam logic [capture_depth_log2-1:0] last_addr = '1; // Final capture address

    gem_pkg::capture_state_t state;                      // Capture sequence state
    logic                    trigger;                    // Frame holds a valid cluster

    assign trigger = |vpf;                               // Any lane with a valid cluster arms it
    assign wr_en   = state == gem_pkg::capture_writing;  // Write every cycle of the sweep

    // --------------------------------------------------------------------------
    // State machine and write address counter
    // --------------------------------------------------------------------------

    always_ff @(posedge clock) begin
        if (reset || resync) begin
            state   <= gem_pkg::capture_idle;
            wr_addr <= '0;
        end else begin
            case (state)
                gem_pkg::capture_idle: begin
                    wr_addr <= '0;                       // Next record starts at address 0
                    if (trigger) begin
                        state <= gem_pkg::capture_writing;
                    end
                end
                gem_pkg::capture_writing: begin
                    wr_addr <= wr_addr + 1'b1;
                    if (wr_addr == last_addr) begin      // Last address written this edge
                        state <= gem_pkg::capture_readout;
                    end
                end
                gem_pkg::capture_readout: begin
                    if (rearm) begin
                        state <= gem_pkg::capture_idle;
                    end
                end
                default: begin
                    state <= gem_pkg::capture_idle;      // Unused encoding recovers to idle
                end
            endcase
        end
    end

    // Full flag follows readout by one cycle and drops on the rearm edge
    always_ff @(posedge clock) begin
        if (reset || resync) begin
            capture_full <= 1'b0;
        end else begin
            capture_full <= (state == gem_pkg::capture_readout) && !rearm;
        end
    end

endmodule

`default_nettype wire

// ==== src/gem_rawhits_lane.sv ====
`timescale 1ns/1ps
`default_nettype none

// --------------------------------------------------------------------------
// One cluster lane of capture RAM with odd parity per word
// --------------------------------------------------------------------------

module gem_rawhits_lane #(
    parameter int capture_depth_log2 = 10
) (
    input  wire logic                          clock,
    input  wire logic                          wr_en,        // Write strobe from controller
    input  wire logic [capture_depth_log2-1:0] wr_addr,
    input  wire gem_pkg::gem_cluster_t         wr_cluster,   // Decoded cluster for this lane
    input  wire logic [capture_depth_log2-1:0] rd_addr,      // Readout address
    output gem_pkg::gem_cluster_t              rd_cluster,   // Stored cluster, one cycle later
    output logic                               parity_err    // Stored parity disagrees
);

    localparam int depth      = 2 ** capture_depth_log2;
    localparam int data_width = $bits(gem_pkg::gem_cluster_t);

    logic [data_width:0] mem [depth];                    // Parity bit on top of the cluster
    logic [data_width:0] rd_word;                        // Registered read port
    logic                wr_parity;                      // Odd parity of the write data
    logic                rd_parity;                      // Parity recomputed on readback

    assign wr_parity = ~(^wr_cluster);

    // Write port
    always_ff @(posedge clock) begin
        if (wr_en) begin
            mem[wr_addr] <= {wr_parity, wr_cluster};
        end
    end

    // Synchronous read port, free running
    always_ff @(posedge clock) begin
        rd_word <= mem[rd_addr];
    end

    assign rd_cluster = rd_word[data_width-1:0];
    assign rd_parity  = ~(^rd_word[data_width-1:0]);
    assign parity_err = rd_word[data_width] != rd_parity; // Flip anywhere in the word

endmodule

`default_nettype wire

// ==== src/gem_rawhits_bank.sv ====
`timescale 1ns/1ps
`default_nettype none

// --------------------------------------------------------------------------
// Raw hits bank: four cluster lanes written together, one read out at a time
// --------------------------------------------------------------------------

module gem_rawhits_bank #(
    parameter int capture_depth_log2 = 10
) (
    input  wire logic                          clock,
    input  wire logic                          wr_en,        // Common write strobe
    input  wire logic [capture_depth_log2-1:0] wr_addr,      // Common write address
    input  wire gem_pkg::gem_cluster_t         cluster0,
    input  wire gem_pkg::gem_cluster_t         cluster1,
    input  wire gem_pkg::gem_cluster_t         cluster2,
    input  wire gem_pkg::gem_cluster_t         cluster3,
    input  wire logic [capture_depth_log2-1:0] rd_addr,      // Readout address, all lanes
    input  wire logic [1:0]                    rd_sel,       // Lane to return on rd_data
    output gem_pkg::gem_cluster_t              rd_data,      // Selected lane, one cycle later
    output logic [3:0]                         parity_err    // Per-lane parity check
);

    gem_pkg::gem_cluster_t wr_cluster [gem_pkg::clusters_per_frame]; // Lane write data
    gem_pkg::gem_cluster_t rd_cluster [gem_pkg::clusters_per_frame]; // Lane read data
    logic [1:0]            rd_sel_q;                     // Select aligned to RAM output

    assign wr_cluster[0] = cluster0;
    assign wr_cluster[1] = cluster1;
    assign wr_cluster[2] = cluster2;
    assign wr_cluster[3] = cluster3;

    // One lane per cluster slot
    for (genvar i = 0; i < gem_pkg::clusters_per_frame; i++) begin : g_lane
        gem_rawhits_lane #(
            .capture_depth_log2 (capture_depth_log2)
        ) u_lane (
            .clock      (clock),
            .wr_en      (wr_en),
            .wr_addr    (wr_addr),
            .wr_cluster (wr_cluster[i]),
            .rd_addr    (rd_addr),
            .rd_cluster (rd_cluster[i]),
            .parity_err (parity_err[i])
        );
    end

    // Delay the select by the RAM read latency
    always_ff @(posedge clock) begin
        rd_sel_q <= rd_sel;
    end

    assign rd_data = rd_cluster[rd_sel_q];               // Output mux

endmodule

`default_nettype wire

// ==== src/gem_frontend.sv ====
`timescale 1ns/1ps
`default_nettype none

// --------------------------------------------------------------------------
// GEM trigger link front end: decode, capture control, raw hits bank
// --------------------------------------------------------------------------

module gem_frontend #(
    parameter int capture_depth_log2 = 10                // Raw hits depth, log2
) (
    input  wire logic                          clock,
    input  wire logic                          reset,
    input  wire gem_pkg::gem_frame_t           frame,        // Link frame, one per clock
    input  wire logic                          resync,       // Fast control resync
    input  wire logic                          rearm,        // Release capture record
    input  wire logic [capture_depth_log2-1:0] rd_addr,      // Raw hits read address
    input  wire logic [1:0]                    rd_sel,       // Raw hits lane select
    output gem_pkg::gem_cluster_t              cluster0,
    output gem_pkg::gem_cluster_t              cluster1,
    output gem_pkg::gem_cluster_t              cluster2,
    output gem_pkg::gem_cluster_t              cluster3,
    output logic [3:0]                         vpf,          // Valid flag per cluster
    output logic                               nonzero,      // Frame not all zero
    output logic                               capture_full, // Raw hits record ready
    output gem_pkg::gem_cluster_t              rd_data,      // Raw hits read data
    output logic [3:0]                         parity_err    // Raw hits parity per lane
);

    logic                          wr_en;                // Capture write strobe
    logic [capture_depth_log2-1:0] wr_addr;              // Capture write address

    // --------------------------------------------------------------------------
    // Frame decode
    // --------------------------------------------------------------------------

    gem_cluster_decode u_decode (
        .clock    (clock),
        .reset    (reset),
        .frame    (frame),
        .cluster0 (cluster0),
        .cluster1 (cluster1),
        .cluster2 (cluster2),
        .cluster3 (cluster3),
        .vpf      (vpf),
        .nonzero  (nonzero)
    );

    // --------------------------------------------------------------------------
    // Capture control and storage
    // --------------------------------------------------------------------------

    gem_capture_ctrl #(
        .capture_depth_log2 (capture_depth_log2)
    ) u_ctrl (
        .clock        (clock),
        .reset        (reset),
        .resync       (resync),
        .rearm        (rearm),
        .vpf          (vpf),                             // Triggers on any valid cluster
        .wr_en        (wr_en),
        .wr_addr      (wr_addr),
        .capture_full (capture_full)
    );

    gem_rawhits_bank #(
        .capture_depth_log2 (capture_depth_log2)
    ) u_bank (
        .clock      (clock),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .cluster0   (cluster0),                          // Stores the decoded clusters
        .cluster1   (cluster1),
        .cluster2   (cluster2),
        .cluster3   (cluster3),
        .rd_addr    (rd_addr),
        .rd_sel     (rd_sel),
        .rd_data    (rd_data),
        .parity_err (parity_err)
    );

endmodule

`default_nettype wire

// ==== tb/gem_frontend_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

// --------------------------------------------------------------------------
// Capture controller checks, bound into every gem_capture_ctrl
// --------------------------------------------------------------------------

module gem_frontend_properties #(
    parameter int capture_depth_log2 = 10
) (
    input wire logic                          clock,
    input wire logic                          reset,
    input wire logic                          resync,
    input wire logic                          wr_en,
    input wire logic [capture_depth_log2-1:0] wr_addr,
    input wire logic                          capture_full,
    input wire gem_pkg::capture_state_t       state
);

    // Writing state opens its sweep at address 0
    wr_sweep_start: assert property (@(posedge clock) disable iff (reset)
        $rose(wr_en) |-> wr_addr == '0)
        else $error("wr_en rose with wr_addr not at address 0");

    // Writing state is left right after the last address
    wr_sweep_end: assert property (@(posedge clock) disable iff (reset)
        (wr_en && &wr_addr) |=> !wr_en)
        else $error("wr_en still high after the last address");

    // Address steps by one across back to back writes
    wr_addr_step: assert property (@(posedge clock) disable iff (reset)
        (wr_en ##1 wr_en) |-> wr_addr == capture_depth_log2'($past(wr_addr) + 1'b1))
        else $error("wr_addr did not increment between writes");

    full_excludes_write: assert property (@(posedge clock) disable iff (reset)
        !(capture_full && wr_en))
        else $error("capture_full and wr_en high together");

    idle_after_reset: assert property (@(posedge clock)
        (reset || resync) |=> state == gem_pkg::capture_idle)
        else $error("state not idle after reset or resync");

endmodule

bind gem_capture_ctrl gem_frontend_properties #(
    .capture_depth_log2 (capture_depth_log2)
) u_props (
    .clock        (clock),
    .reset        (reset),
    .resync       (resync),
    .wr_en        (wr_en),
    .wr_addr      (wr_addr),
    .capture_full (capture_full),
    .state        (state)
);

`default_nettype wire

// ==== tb/gem_frontend_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module gem_frontend_tb;

    localparam int depth_log2 = 5;
    localparam int depth      = 2 ** depth_log2;
    localparam int table_len  = 160;
    localparam int cw         = $bits(gem_pkg::gem_cluster_t); // 14 bit cluster slice
    localparam longint timeout_ns = (table_len + 4 * depth + 200) * 10;
    localparam gem_pkg::gem_frame_t idle_frame = '1;       // Every prefix 11, nothing valid

    logic                      clock;
    logic                      reset;
    gem_pkg::gem_frame_t       frame;
    logic                      resync;
    logic                      rearm;
    logic [depth_log2-1:0]     rd_addr;
    logic [1:0]                rd_sel;
    gem_pkg::gem_cluster_t     cluster0;
    gem_pkg::gem_cluster_t     cluster1;
    gem_pkg::gem_cluster_t     cluster2;
    gem_pkg::gem_cluster_t     cluster3;
    logic [3:0]                vpf;
    logic                      nonzero;
    logic                      capture_full;
    gem_pkg::gem_cluster_t     rd_data;
    logic [3:0]                parity_err;

    gem_pkg::gem_frame_t tbl_frame [table_len];             // Stimulus table
    logic [3:0]          tbl_vpf   [table_len];             // Expected valid flags
    logic [31:0]         lfsr_state = 32'hbe59;
    int                  err_count   = 0;
    int                  check_count = 0;

    // Reference model state
    gem_pkg::gem_frame_t rec_q [$];                         // Frames of the capture in progress
    gem_pkg::gem_frame_t held_rec [depth];                  // Last complete record
    logic                m_idle = 1'b1;
    logic                m_writing = 1'b0;
    logic                m_held = 1'b0;
    longint              edge_n = 0;
    longint              trig_edge = 0;
    longint              full_edge = 0;

    // Inputs driven last cycle, sampled at the current edge
    gem_pkg::gem_frame_t   p_frame = idle_frame;
    logic [3:0]            p_vpf = 4'h0;
    logic                  p_rearm = 1'b0;
    logic                  p_resync = 1'b0;
    logic [depth_log2-1:0] p_rd_addr = '0;
    logic [1:0]            p_rd_sel = '0;
    logic                  p_rd_check = 1'b0;

    gem_frontend #(
        .capture_depth_log2 (depth_log2)
    ) DUT (
        .clock        (clock),
        .reset        (reset),
        .frame        (frame),
        .resync       (resync),
        .rearm        (rearm),
        .rd_addr      (rd_addr),
        .rd_sel       (rd_sel),
        .cluster0     (cluster0),
        .cluster1     (cluster1),
        .cluster2     (cluster2),
        .cluster3     (cluster3),
        .vpf          (vpf),
        .nonzero      (nonzero),
        .capture_full (capture_full),
        .rd_data      (rd_data),
        .parity_err   (parity_err)
    );

    always #5 clock = ~clock;                               // 10 ns period

    // --------------------------------------------------------------------------
    // Helpers
    // --------------------------------------------------------------------------

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1); // Galois taps 32,22,2,1
    endfunction

    task automatic random_frame(output gem_pkg::gem_frame_t f);
        for (int b = 0; b < $bits(f); b++) begin
            lfsr_state = lfsr_next(lfsr_state);
            f[b] = lfsr_state[0];                           // One step per bit taken
        end
    endtask

    function automatic gem_pkg::gem_cluster_t make_cluster(input logic [2:0] size,
                                                           input logic [10:0] addr);
        make_cluster = {size, addr};
    endfunction

    // Valid unless the top two address bits are both set
    function automatic logic [3:0] expected_vpf(input gem_pkg::gem_frame_t f);
        for (int i = 0; i < 4; i++) begin
            expected_vpf[i] = f[i*cw+10 -: 2] != 2'b11;
        end
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("[FAIL] %0t ns %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // --------------------------------------------------------------------------
    // Per cycle drive, model update and checks
    // --------------------------------------------------------------------------

    task automatic check_sampled();
        logic exp_full;
        edge_n++;
        check_value("cluster0", cluster0, p_frame[0*cw +: cw]);
        check_value("cluster1", cluster1, p_frame[1*cw +: cw]);
        check_value("cluster2", cluster2, p_frame[2*cw +: cw]);
        check_value("cluster3", cluster3, p_frame[3*cw +: cw]);
        check_value("vpf", vpf, p_vpf);
        check_value("nonzero", nonzero, |p_frame);
        if (p_resync) begin                                 // Back to armed from any state
            m_writing = 1'b0;
            m_held    = 1'b0;
            m_idle    = 1'b1;
        end
        if (p_rearm && m_held && edge_n >= full_edge) begin
            m_held = 1'b0;
            m_idle = 1'b1;
        end
        if (m_idle && p_vpf != 4'h0) begin                  // Trigger frame itself not stored
            m_idle    = 1'b0;
            m_writing = 1'b1;
            trig_edge = edge_n;
            rec_q.delete();
        end else if (m_writing) begin
            rec_q.push_back(p_frame);
            if (rec_q.size() == depth) begin
                m_writing = 1'b0;
                m_held    = 1'b1;
                full_edge = trig_edge + depth + 2;
                for (int i = 0; i < depth; i++) begin
                    held_rec[i] = rec_q[i];
                end
            end
        end
        exp_full = m_held && edge_n >= full_edge;
        check_value("capture_full", capture_full, exp_full);
        if (p_rd_check) begin
            check_value("rd_data", rd_data, held_rec[p_rd_addr][p_rd_sel*cw +: cw]);
            check_value("parity_err", parity_err, 4'h0);
        end
    endtask

    task automatic run_cycle(input gem_pkg::gem_frame_t f, input logic [3:0] v,
                             input logic ra, input logic rs,
                             input logic [depth_log2-1:0] addr, input logic [1:0] sel,
                             input logic chk);
        @(posedge clock);
        frame   <= f;
        rearm   <= ra;
        resync  <= rs;
        rd_addr <= addr;
        rd_sel  <= sel;
        @(negedge clock);                                   // Outputs settled here
        check_sampled();
        p_frame    = f;
        p_vpf      = v;
        p_rearm    = ra;
        p_resync   = rs;
        p_rd_addr  = addr;
        p_rd_sel   = sel;
        p_rd_check = chk;
    endtask

    task automatic apply_table(input int lo, input int hi, input int resync_idx);
        for (int i = lo; i <= hi; i++) begin
            run_cycle(tbl_frame[i], tbl_vpf[i], 1'b0, i == resync_idx, '0, 2'd0, 1'b0);
        end
    endtask

    task automatic read_all_lanes();
        for (int a = 0; a < depth; a++) begin
            for (int l = 0; l < 4; l++) begin
                run_cycle(idle_frame, 4'h0, 1'b0, 1'b0, a[depth_log2-1:0], l[1:0], 1'b1);
            end
        end
    endtask

    task automatic read_one_lane_each();
        for (int a = 0; a < depth; a++) begin
            run_cycle(idle_frame, 4'h0, 1'b0, 1'b0, a[depth_log2-1:0], a[1:0], 1'b1);
        end
    endtask

    task automatic fill_table();
        gem_pkg::gem_frame_t f;
        for (int i = 0; i < table_len; i++) begin
            random_frame(f);
            if (i >= 4 && i < 24) begin
                for (int c = 0; c < 4; c++) begin
                    f[c*cw+10 -: 2] = 2'b11;                // Arming phase stays invalid
                end
            end
            tbl_frame[i] = f;
            tbl_vpf[i]   = expected_vpf(f);
        end
        // Hand-written entries, all invalid
        tbl_frame[0] = '1;
        tbl_frame[1] = {4{make_cluster(3'd0, 11'h600)}};
        tbl_frame[2] = {make_cluster(3'd7, 11'h7ff), make_cluster(3'd0, 11'h7ff),
                        make_cluster(3'd5, 11'h7ff), make_cluster(3'd2, 11'h7ff)};
        tbl_frame[3] = {make_cluster(3'd4, 11'h6a5), make_cluster(3'd3, 11'h6a5),
                        make_cluster(3'd2, 11'h6a5), make_cluster(3'd1, 11'h6a5)};
        for (int i = 0; i < 4; i++) begin
            tbl_vpf[i] = 4'h0;
        end
        // Single valid lanes and boundary addresses
        tbl_frame[24] = {{3{make_cluster(3'd7, 11'h7ff)}}, make_cluster(3'd0, 11'h000)};
        tbl_vpf[24]   = 4'b0001;
        tbl_frame[25] = {{2{make_cluster(3'd1, 11'h600)}}, make_cluster(3'd2, 11'h5ff),
                         make_cluster(3'd1, 11'h600)};
        tbl_vpf[25]   = 4'b0010;
        tbl_frame[26] = {make_cluster(3'd0, 11'h7ff), make_cluster(3'd7, 11'h400),
                         {2{make_cluster(3'd0, 11'h7ff)}}};
        tbl_vpf[26]   = 4'b0100;
        tbl_frame[27] = {make_cluster(3'd3, 11'h3ff), {3{make_cluster(3'd3, 11'h6ff)}}};
        tbl_vpf[27]   = 4'b1000;
        tbl_frame[28] = '0;
        tbl_vpf[28]   = 4'b1111;
        tbl_frame[29] = {4{make_cluster(3'd7, 11'h5ff)}};
        tbl_vpf[29]   = 4'b1111;
        tbl_frame[64] = {make_cluster(3'd0, 11'h7ff), make_cluster(3'd6, 11'h123),
                         {2{make_cluster(3'd0, 11'h7ff)}}};
        tbl_vpf[64]   = 4'b0100;
        tbl_frame[112] = {{3{make_cluster(3'd0, 11'h7ff)}}, make_cluster(3'd2, 11'h0aa)};
        tbl_vpf[112]   = 4'b0001;
        tbl_frame[120] = {make_cluster(3'd5, 11'h255), {3{make_cluster(3'd0, 11'h7ff)}}};
        tbl_vpf[120]   = 4'b1000;
    endtask

    // --------------------------------------------------------------------------
    // Main sequence and watchdog
    // --------------------------------------------------------------------------

    initial begin
        clock   = 1'b0;
        reset   = 1'b1;
        frame   = idle_frame;
        resync  = 1'b0;
        rearm   = 1'b0;
        rd_addr = '0;
        rd_sel  = '0;
        fill_table();
        repeat (16) @(posedge clock);
        reset <= 1'b0;
        apply_table(0, 63, -1);                              // Arm, trigger at 24, capture
        read_all_lanes();
        run_cycle(idle_frame, 4'h0, 1'b1, 1'b0, '0, 2'd0, 1'b0); // Rearm
        apply_table(64, 111, -1);                            // New record overwrites old
        read_one_lane_each();
        run_cycle(idle_frame, 4'h0, 1'b1, 1'b0, '0, 2'd0, 1'b0);
        apply_table(112, 159, 120);                          // Resync in mid capture
        read_all_lanes();
        run_cycle(idle_frame, 4'h0, 1'b0, 1'b0, '0, 2'd0, 1'b0); // Flush last checks
        $display("Checks run %0d, errors %0d", check_count, err_count);
        if (err_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    initial begin
        #(timeout_ns);
        $display("Timeout: the run did not finish in %0d ns", timeout_ns);
        $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== gem_frontend.f ====
src/gem_pkg.sv
src/gem_cluster_decode.sv
src/gem_capture_ctrl.sv
src/gem_rawhits_lane.sv
src/gem_rawhits_bank.sv
src/gem_frontend.sv
tb/gem_frontend_properties.sv
tb/gem_frontend_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := gem_frontend_tb
FILELIST  := gem_frontend.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "Everything OK" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
